/* mmu_settings.svh */
`ifndef MMU_SETTINGS_SVH
`define MMU_SETTINGS_SVH

// Lane 0 is instruction fetch, the rest are data lanes
`define MMU_N_LANES     3

`define MMU_TLB_ENTRIES 16
`define MMU_TLB_IDX_W   4   // log2 of MMU_TLB_ENTRIES

`define MMU_ASID_W      10

`endif

/* mmu_addr_pkg.sv */
package mmu_addr_pkg;

    typedef struct packed {
        logic [18:0] vppn;      // Virtual page pair number
        logic        odd;       // Selects odd page of the pair
        logic [11:0] offset;
    } va_page_t;

    typedef struct packed {
        logic [2:0]  seg;       // Matched against window vseg
        logic [28:0] rem;
    } va_win_t;

    // Same word, read as a TLB lookup or a window lookup
    typedef union packed {
        va_page_t page;
        va_win_t  win;
    } va_u;

    typedef enum logic [1:0] {
        MAT_SUC = 2'd0,         // Strongly-ordered uncached
        MAT_CC  = 2'd1          // Coherent cached
    } mat_e;

    typedef enum logic [2:0] {
        EXC_NONE = 3'd0,
        EXC_TLBR = 3'd1,
        EXC_PIL  = 3'd2,
        EXC_PIS  = 3'd3,
        EXC_PIF  = 3'd4,
        EXC_PPI  = 3'd5,
        EXC_PME  = 3'd6
    } exc_e;

    typedef struct packed {
        logic [2:0]  vseg;
        logic        rsv_28;
        logic [2:0]  pseg;
        logic [18:0] rsv_24_6;
        mat_e        mat;
        logic        plv3;
        logic [1:0]  rsv_2_1;
        logic        plv0;
    } dmw_t;

endpackage

/* mmu_tlb_pkg.sv */
`include "mmu_settings.svh"

package mmu_tlb_pkg;

    // One 4 KiB page of an entry
    typedef struct packed {
        logic        valid;
        logic        dirty;
        logic [1:0]  mat;
        logic [1:0]  plv;       // Lowest privilege allowed to access
        logic [19:0] ppn;
    } tlb_half_t;

    typedef struct packed {
        logic                   exist;
        logic [18:0]            vppn;
        logic [`MMU_ASID_W-1:0] asid;
        logic                   g;      // Global, ignores ASID
        tlb_half_t              even;
        tlb_half_t              odd;
    } tlb_entry_t;

    typedef struct packed {
        logic                      found;
        logic [`MMU_TLB_IDX_W-1:0] index;
        tlb_half_t                 half;
    } tlb_result_t;

endpackage

/* mmu_tlb.sv */
`timescale 1ns/1ps
`include "mmu_settings.svh"

module mmu_tlb (
    input  logic                                              clk,
    input  logic                                              i_arst_n,

    input  logic [`MMU_N_LANES-1:0][18:0]                     i_s_vppn,
    input  logic [`MMU_N_LANES-1:0]                           i_s_odd,
    input  logic [`MMU_N_LANES-1:0][`MMU_ASID_W-1:0]          i_s_asid,
    output mmu_tlb_pkg::tlb_result_t [`MMU_N_LANES-1:0]       o_s_result,

    input  logic                                              i_we,
    input  logic [`MMU_TLB_IDX_W-1:0]                         i_w_index,
    input  mmu_tlb_pkg::tlb_entry_t                           i_w_entry,
    input  logic [`MMU_TLB_IDX_W-1:0]                         i_r_index,
    output mmu_tlb_pkg::tlb_entry_t                           o_r_entry,

    input  logic                                              i_inv_valid,
    input  logic [4:0]                                        i_inv_op,
    input  logic [`MMU_ASID_W-1:0]                            i_inv_asid,
    input  mmu_addr_pkg::va_u                                 i_inv_va
);

    import mmu_tlb_pkg::*;

    tlb_entry_t                                  ent_q [`MMU_TLB_ENTRIES];
    logic [`MMU_TLB_ENTRIES-1:0]                 exist_q;   // Only part of an entry under reset
    logic [`MMU_N_LANES-1:0][`MMU_TLB_ENTRIES-1:0] s_hit;
    logic [`MMU_TLB_ENTRIES-1:0]                 inv_asid_m;
    logic [`MMU_TLB_ENTRIES-1:0]                 inv_va_m;
    logic [`MMU_TLB_ENTRIES-1:0]                 inv_hit;

    // Associative search, lowest matching index wins
    always_comb begin
        for (int l = 0; l < `MMU_N_LANES; l++) begin
            o_s_result[l] = '0;
            for (int i = 0; i < `MMU_TLB_ENTRIES; i++) begin
                s_hit[l][i] = exist_q[i] && (ent_q[i].vppn == i_s_vppn[l])
                              && (ent_q[i].g || ent_q[i].asid == i_s_asid[l]);
                if (s_hit[l][i] && !o_s_result[l].found) begin
                    o_s_result[l].found = 1'b1;
                    o_s_result[l].index = `MMU_TLB_IDX_W'(i);
                    o_s_result[l].half  = i_s_odd[l] ? ent_q[i].odd : ent_q[i].even;
                end
            end
        end
    end

    // Invalidate selection by op
    always_comb begin
        for (int i = 0; i < `MMU_TLB_ENTRIES; i++) begin
            inv_asid_m[i] = ent_q[i].asid == i_inv_asid;
            inv_va_m[i]   = ent_q[i].vppn == i_inv_va.page.vppn;
            case (i_inv_op)
                5'd0, 5'd1: inv_hit[i] = 1'b1;
                5'd2:       inv_hit[i] = ent_q[i].g;
                5'd3:       inv_hit[i] = !ent_q[i].g;
                5'd4:       inv_hit[i] = !ent_q[i].g && inv_asid_m[i];
                5'd5:       inv_hit[i] = !ent_q[i].g && inv_asid_m[i] && inv_va_m[i];
                5'd6:       inv_hit[i] = (ent_q[i].g || inv_asid_m[i]) && inv_va_m[i];
                default:    inv_hit[i] = 1'b0;
            endcase
        end
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            exist_q <= '0;
        end else begin
            if (i_inv_valid) begin
                exist_q <= exist_q & ~inv_hit;
            end
            if (i_we) begin
                exist_q[i_w_index] <= i_w_entry.exist;  // Write overrides invalidate
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_we) begin
            ent_q[i_w_index] <= i_w_entry;
        end
    end

    always_comb begin
        o_r_entry       = ent_q[i_r_index];
        o_r_entry.exist = exist_q[i_r_index];
    end

endmodule

/* addr_trans.sv */
`timescale 1ns/1ps
`include "mmu_settings.svh"

module addr_trans #(
    parameter bit IS_FETCH = 1'b0
) (
    input  logic                      i_da,
    input  mmu_addr_pkg::mat_e        i_da_mat,
    input  logic [1:0]                i_plv,
    input  logic [`MMU_ASID_W-1:0]    i_asid,
    input  mmu_addr_pkg::dmw_t        i_dmw0,
    input  mmu_addr_pkg::dmw_t        i_dmw1,

    input  mmu_addr_pkg::va_u         i_va,
    input  logic                      i_we,

    output logic [18:0]               o_s_vppn,
    output logic                      o_s_odd,
    output logic [`MMU_ASID_W-1:0]    o_s_asid,
    input  mmu_tlb_pkg::tlb_result_t  i_s_result,

    output logic [31:0]               o_pa,
    output mmu_addr_pkg::mat_e        o_mat,
    output mmu_addr_pkg::exc_e        o_exc
);

    import mmu_addr_pkg::*;
    import mmu_tlb_pkg::*;

    logic      dmw0_hit;
    logic      dmw1_hit;
    tlb_half_t page;

    assign o_s_vppn = i_va.page.vppn;
    assign o_s_odd  = i_va.page.odd;
    assign o_s_asid = i_asid;

    // Window needs a segment match and an enabled privilege level
    assign dmw0_hit = (i_dmw0.vseg == i_va.win.seg)
                      && ((i_plv == 2'd0 && i_dmw0.plv0) || (i_plv == 2'd3 && i_dmw0.plv3));
    assign dmw1_hit = (i_dmw1.vseg == i_va.win.seg)
                      && ((i_plv == 2'd0 && i_dmw1.plv0) || (i_plv == 2'd3 && i_dmw1.plv3));

    assign page = i_s_result.half;

    always_comb begin
        o_exc = EXC_NONE;
        if (i_da) begin
            o_pa  = i_va;
            o_mat = i_da_mat;
        end else if (dmw0_hit) begin
            o_pa  = {i_dmw0.pseg, i_va.win.rem};
            o_mat = i_dmw0.mat;
        end else if (dmw1_hit) begin
            o_pa  = {i_dmw1.pseg, i_va.win.rem};
            o_mat = i_dmw1.mat;
        end else begin
            o_pa  = {page.ppn, i_va.page.offset};
            o_mat = mat_e'(page.mat);
            if (!i_s_result.found) begin
                o_exc = EXC_TLBR;
            end else if (!page.valid) begin
                if (IS_FETCH) begin
                    o_exc = EXC_PIF;
                end else begin
                    o_exc = i_we ? EXC_PIS : EXC_PIL;
                end
            end else if (i_plv > page.plv) begin
                o_exc = EXC_PPI;
            end else if (i_we && !page.dirty) begin
                o_exc = EXC_PME;
            end
        end
    end

endmodule

/* mem_req_arbiter.sv */
`timescale 1ns/1ps
`include "mmu_settings.svh"

module mem_req_arbiter (
    input  logic                                        clk,
    input  logic                                        i_arst_n,

    input  logic [`MMU_N_LANES-1:0]                     i_req_valid,
    output logic [`MMU_N_LANES-1:0]                     o_req_ready,
    input  logic [`MMU_N_LANES-1:0]                     i_req_we,
    input  logic [`MMU_N_LANES-1:0][3:0]                i_req_wstrb,
    input  logic [`MMU_N_LANES-1:0][31:0]               i_req_wdata,
    input  logic [`MMU_N_LANES-1:0][31:0]               i_pa,
    input  mmu_addr_pkg::mat_e [`MMU_N_LANES-1:0]       i_mat,
    input  mmu_addr_pkg::exc_e [`MMU_N_LANES-1:0]       i_exc,

    output logic                                        o_mem_req_valid,
    input  logic                                        i_mem_req_ready,
    output logic [31:0]                                 o_mem_addr,
    output logic                                        o_mem_we,
    output logic [3:0]                                  o_mem_wstrb,
    output logic [31:0]                                 o_mem_wdata,
    output logic                                        o_mem_uncached,
    input  logic                                        i_mem_rsp_valid,
    input  logic [31:0]                                 i_mem_rsp_rdata,

    output logic [`MMU_N_LANES-1:0]                     o_rsp_valid,
    output mmu_addr_pkg::exc_e [`MMU_N_LANES-1:0]       o_rsp_exc,
    output logic [`MMU_N_LANES-1:0][31:0]               o_rsp_rdata
);

    import mmu_addr_pkg::*;

    localparam int LANE_W = $clog2(`MMU_N_LANES);

    logic [LANE_W-1:0]       rr_ptr_q;
    logic [LANE_W-1:0]       owner_q;
    logic [LANE_W-1:0]       gnt_idx;
    logic                    gnt_valid;
    logic                    busy_q;
    logic                    accept;
    logic                    is_fault;
    logic [`MMU_N_LANES-1:0] rsp_valid_q;
    exc_e                    rsp_exc_q;
    logic [31:0]             rsp_rdata_q;

    // First valid lane at or after the pointer
    always_comb begin
        int cand;
        cand      = 0;
        gnt_valid = 1'b0;
        gnt_idx   = '0;
        for (int k = 0; k < `MMU_N_LANES; k++) begin
            cand = int'(rr_ptr_q) + k;
            if (cand >= `MMU_N_LANES) begin
                cand = cand - `MMU_N_LANES;
            end
            if (!gnt_valid && i_req_valid[cand]) begin
                gnt_valid = 1'b1;
                gnt_idx   = LANE_W'(cand);
            end
        end
    end

    assign accept   = !busy_q && gnt_valid;
    assign is_fault = i_exc[gnt_idx] != EXC_NONE;

    always_comb begin
        for (int l = 0; l < `MMU_N_LANES; l++) begin
            o_req_ready[l] = accept && (gnt_idx == LANE_W'(l));
            o_rsp_exc[l]   = rsp_exc_q;
            o_rsp_rdata[l] = rsp_rdata_q;
        end
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            rr_ptr_q        <= '0;
            owner_q         <= '0;
            busy_q          <= 1'b0;
            o_mem_req_valid <= 1'b0;
            rsp_valid_q     <= '0;
        end else begin
            rsp_valid_q <= '0;
            if (o_mem_req_valid && i_mem_req_ready) begin
                o_mem_req_valid <= 1'b0;
            end
            if (accept) begin
                rr_ptr_q <= (gnt_idx == LANE_W'(`MMU_N_LANES - 1)) ? '0 : gnt_idx + 1'b1;
                if (is_fault) begin
                    rsp_valid_q[gnt_idx] <= 1'b1;   // Answered here, memory never sees it
                end else begin
                    busy_q          <= 1'b1;
                    owner_q         <= gnt_idx;
                    o_mem_req_valid <= 1'b1;
                end
            end
            if (busy_q && i_mem_rsp_valid) begin
                busy_q               <= 1'b0;
                rsp_valid_q[owner_q] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept && !is_fault) begin
            o_mem_addr     <= i_pa[gnt_idx];
            o_mem_we       <= i_req_we[gnt_idx];
            o_mem_wstrb    <= i_req_wstrb[gnt_idx];
            o_mem_wdata    <= i_req_wdata[gnt_idx];
            o_mem_uncached <= i_mat[gnt_idx] == MAT_SUC;
        end
        if (accept && is_fault) begin
            rsp_exc_q   <= i_exc[gnt_idx];
            rsp_rdata_q <= '0;
        end else if (busy_q && i_mem_rsp_valid) begin
            rsp_exc_q   <= EXC_NONE;
            rsp_rdata_q <= i_mem_rsp_rdata;
        end
    end

    assign o_rsp_valid = rsp_valid_q;

endmodule

/* mmu_top.sv */
`timescale 1ns/1ps
`include "mmu_settings.svh"

module mmu_top (
    input  logic                                        clk,
    input  logic                                        i_arst_n,

    input  logic                                        i_da,
    input  mmu_addr_pkg::mat_e                          i_datf,
    input  mmu_addr_pkg::mat_e                          i_datm,
    input  logic [1:0]                                  i_plv,
    input  logic [`MMU_ASID_W-1:0]                      i_asid,
    input  mmu_addr_pkg::dmw_t                          i_dmw0,
    input  mmu_addr_pkg::dmw_t                          i_dmw1,

    input  logic [`MMU_N_LANES-1:0]                     i_req_valid,
    output logic [`MMU_N_LANES-1:0]                     o_req_ready,
    input  mmu_addr_pkg::va_u [`MMU_N_LANES-1:0]        i_req_va,
    input  logic [`MMU_N_LANES-1:0]                     i_req_we,
    input  logic [`MMU_N_LANES-1:0][3:0]                i_req_wstrb,
    input  logic [`MMU_N_LANES-1:0][31:0]               i_req_wdata,
    output logic [`MMU_N_LANES-1:0]                     o_rsp_valid,
    output mmu_addr_pkg::exc_e [`MMU_N_LANES-1:0]       o_rsp_exc,
    output logic [`MMU_N_LANES-1:0][31:0]               o_rsp_rdata,

    output logic                                        o_mem_req_valid,
    input  logic                                        i_mem_req_ready,
    output logic [31:0]                                 o_mem_addr,
    output logic                                        o_mem_we,
    output logic [3:0]                                  o_mem_wstrb,
    output logic [31:0]                                 o_mem_wdata,
    output logic                                        o_mem_uncached,
    input  logic                                        i_mem_rsp_valid,
    input  logic [31:0]                                 i_mem_rsp_rdata,

    input  logic                                        i_tlb_we,
    input  logic [`MMU_TLB_IDX_W-1:0]                   i_tlb_w_index,
    input  mmu_tlb_pkg::tlb_entry_t                     i_tlb_w_entry,
    input  logic [`MMU_TLB_IDX_W-1:0]                   i_tlb_r_index,
    output mmu_tlb_pkg::tlb_entry_t                     o_tlb_r_entry,
    input  logic                                        i_inv_valid,
    input  logic [4:0]                                  i_inv_op,
    input  logic [`MMU_ASID_W-1:0]                      i_inv_asid,
    input  mmu_addr_pkg::va_u                           i_inv_va
);

    import mmu_addr_pkg::*;
    import mmu_tlb_pkg::*;

    logic [`MMU_N_LANES-1:0][18:0]            s_vppn;
    logic [`MMU_N_LANES-1:0]                  s_odd;
    logic [`MMU_N_LANES-1:0][`MMU_ASID_W-1:0] s_asid;
    tlb_result_t [`MMU_N_LANES-1:0]           s_result;
    logic [`MMU_N_LANES-1:0][31:0]            lane_pa;
    mat_e [`MMU_N_LANES-1:0]                  lane_mat;
    exc_e [`MMU_N_LANES-1:0]                  lane_exc;

    mmu_tlb u_tlb (
        .clk         (clk),
        .i_arst_n    (i_arst_n),
        .i_s_vppn    (s_vppn),
        .i_s_odd     (s_odd),
        .i_s_asid    (s_asid),
        .o_s_result  (s_result),
        .i_we        (i_tlb_we),
        .i_w_index   (i_tlb_w_index),
        .i_w_entry   (i_tlb_w_entry),
        .i_r_index   (i_tlb_r_index),
        .o_r_entry   (o_tlb_r_entry),
        .i_inv_valid (i_inv_valid),
        .i_inv_op    (i_inv_op),
        .i_inv_asid  (i_inv_asid),
        .i_inv_va    (i_inv_va)
    );

    for (genvar l = 0; l < `MMU_N_LANES; l++) begin : g_lane
        addr_trans #(
            .IS_FETCH (l == 0)
        ) u_trans (
            .i_da       (i_da),
            .i_da_mat   ((l == 0) ? i_datf : i_datm),   // Fetch has its own DA mat
            .i_plv      (i_plv),
            .i_asid     (i_asid),
            .i_dmw0     (i_dmw0),
            .i_dmw1     (i_dmw1),
            .i_va       (i_req_va[l]),
            .i_we       (i_req_we[l]),
            .o_s_vppn   (s_vppn[l]),
            .o_s_odd    (s_odd[l]),
            .o_s_asid   (s_asid[l]),
            .i_s_result (s_result[l]),
            .o_pa       (lane_pa[l]),
            .o_mat      (lane_mat[l]),
            .o_exc      (lane_exc[l])
        );
    end

    mem_req_arbiter u_arb (
        .clk             (clk),
        .i_arst_n        (i_arst_n),
        .i_req_valid     (i_req_valid),
        .o_req_ready     (o_req_ready),
        .i_req_we        (i_req_we),
        .i_req_wstrb     (i_req_wstrb),
        .i_req_wdata     (i_req_wdata),
        .i_pa            (lane_pa),
        .i_mat           (lane_mat),
        .i_exc           (lane_exc),
        .o_mem_req_valid (o_mem_req_valid),
        .i_mem_req_ready (i_mem_req_ready),
        .o_mem_addr      (o_mem_addr),
        .o_mem_we        (o_mem_we),
        .o_mem_wstrb     (o_mem_wstrb),
        .o_mem_wdata     (o_mem_wdata),
        .o_mem_uncached  (o_mem_uncached),
        .i_mem_rsp_valid (i_mem_rsp_valid),
        .i_mem_rsp_rdata (i_mem_rsp_rdata),
        .o_rsp_valid     (o_rsp_valid),
        .o_rsp_exc       (o_rsp_exc),
        .o_rsp_rdata     (o_rsp_rdata)
    );

endmodule

/* tb_mmu_asserts.sv */
`timescale 1ns/1ps
`include "mmu_settings.svh"

module tb_mmu_asserts (
    input logic                    clk,
    input logic                    i_arst_n,
    input logic                    busy_q,
    input logic [`MMU_N_LANES-1:0] o_req_ready,
    input logic [`MMU_N_LANES-1:0] o_rsp_valid,
    input logic                    o_mem_req_valid,
    input logic                    i_mem_req_ready,
    input logic [31:0]             o_mem_addr,
    input logic                    o_mem_we,
    input logic [3:0]              o_mem_wstrb,
    input logic [31:0]             o_mem_wdata,
    input logic                    i_mem_rsp_valid
);

    logic mem_pend_q;   // Taken by memory, response not yet back

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            mem_pend_q <= 1'b0;
        end else if (o_mem_req_valid && i_mem_req_ready) begin
            mem_pend_q <= 1'b1;
        end else if (i_mem_rsp_valid) begin
            mem_pend_q <= 1'b0;
        end
    end

    // Request held until the memory takes it
    a_mem_stable: assert property (@(posedge clk) disable iff (!i_arst_n)
        o_mem_req_valid && !i_mem_req_ready |=> o_mem_req_valid && $stable(o_mem_addr)
        && $stable(o_mem_we) && $stable(o_mem_wstrb) && $stable(o_mem_wdata))
        else $error("Memory request changed before accept");

    a_one_rsp: assert property (@(posedge clk) disable iff (!i_arst_n) $onehot0(o_rsp_valid))
        else $error("More than one lane response in a cycle");

    a_rsp_owned: assert property (@(posedge clk) disable iff (!i_arst_n) i_mem_rsp_valid |-> busy_q)
        else $error("Memory response with nothing outstanding");

    a_no_ready_busy: assert property (@(posedge clk) disable iff (!i_arst_n)
        (o_mem_req_valid || mem_pend_q) |-> o_req_ready == '0)
        else $error("Lane ready while a request is outstanding");

endmodule

bind mem_req_arbiter tb_mmu_asserts u_asserts (.*);

/* tb_mmu.sv */
`timescale 1ns/1ps
`include "mmu_settings.svh"

module tb_mmu;
    import mmu_addr_pkg::*;
    import mmu_tlb_pkg::*;

    localparam logic [31:0] RD_KEY     = 32'h5a5a5a5a;
    localparam int          MAX_CYCLES = 3000;  // Tests need about 600

    logic clk, i_arst_n, i_da, i_mem_req_ready, i_mem_rsp_valid;
    mat_e i_datf, i_datm;
    logic [1:0] i_plv;
    logic [`MMU_ASID_W-1:0] i_asid, i_inv_asid;
    dmw_t i_dmw0, i_dmw1;
    logic [`MMU_N_LANES-1:0] i_req_valid, o_req_ready, i_req_we, o_rsp_valid;
    va_u [`MMU_N_LANES-1:0] i_req_va;
    logic [`MMU_N_LANES-1:0][3:0] i_req_wstrb;
    logic [`MMU_N_LANES-1:0][31:0] i_req_wdata, o_rsp_rdata;
    exc_e [`MMU_N_LANES-1:0] o_rsp_exc;
    logic o_mem_req_valid, o_mem_we, o_mem_uncached, i_tlb_we, i_inv_valid;
    logic [31:0] o_mem_addr, o_mem_wdata, i_mem_rsp_rdata;
    logic [3:0] o_mem_wstrb;
    logic [`MMU_TLB_IDX_W-1:0] i_tlb_w_index, i_tlb_r_index;
    tlb_entry_t i_tlb_w_entry, o_tlb_r_entry;
    logic [4:0] i_inv_op;
    va_u i_inv_va;

    int errors, checks, cycles, grant_cnt, mem_cnt;
    logic [31:0] last_addr, last_wdata;
    logic [3:0] last_wstrb;
    logic last_unc, last_we;

    mmu_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles", cycles);
            $display("Checks failed");
            $finish;
        end
    end

    // Grants seen mid-cycle, where ready and valid are settled
    always @(posedge clk) begin
        #3;
        if (|(i_req_valid & o_req_ready)) grant_cnt++;
    end

    // Memory model with random back-pressure and 0 to 3 cycles latency
    initial begin
        int lat;
        logic [31:0] addr;
        i_mem_req_ready = 1'b0;
        i_mem_rsp_valid = 1'b0;
        i_mem_rsp_rdata = '0;
        @(posedge i_arst_n);
        forever begin
            @(posedge clk);
            #1;
            i_mem_rsp_valid = 1'b0;
            i_mem_req_ready = 1'($urandom % 2);
            #2;
            if (o_mem_req_valid && i_mem_req_ready) begin
                addr       = o_mem_addr;
                last_addr  = o_mem_addr;
                last_unc   = o_mem_uncached;
                last_we    = o_mem_we;
                last_wstrb = o_mem_wstrb;
                last_wdata = o_mem_wdata;
                mem_cnt++;
                lat = $urandom % 4;
                @(posedge clk);
                #1;
                i_mem_req_ready = 1'b0;
                if (lat > 0) begin
                    repeat (lat) @(posedge clk);
                    #1;
                end
                i_mem_rsp_valid = 1'b1;
                i_mem_rsp_rdata = addr ^ RD_KEY;
            end
        end
    end

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("error %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic do_req(input int lane, input logic [31:0] va, input logic we,
                          output exc_e exc, output logic [31:0] rdata, output int waits);
        int start_g;
        logic rdy;
        @(posedge clk);
        #1;
        i_req_valid[lane] = 1'b1;
        i_req_va[lane]    = va;
        i_req_we[lane]    = we;
        i_req_wstrb[lane] = 4'hf >> lane;
        i_req_wdata[lane] = ~va;
        start_g = grant_cnt;
        rdy = 1'b0;
        while (!rdy) begin
            #2 rdy = o_req_ready[lane];
            @(posedge clk);
            #1;
        end
        i_req_valid[lane] = 1'b0;
        waits = grant_cnt - start_g - 1;
        while (!o_rsp_valid[lane]) begin
            @(posedge clk);
            #1;
        end
        exc   = o_rsp_exc[lane];
        rdata = o_rsp_rdata[lane];
    endtask

    // One access with the expected code and, when clean, the expected memory address
    task automatic access(input int lane, input logic [31:0] va, input logic we,
                          input exc_e exp_exc, input logic [31:0] exp_pa, input logic exp_unc);
        int m0, waits;
        exc_e exc;
        logic [31:0] rdata;
        m0 = mem_cnt;
        do_req(lane, va, we, exc, rdata, waits);
        check_val("o_rsp_exc", 32'(exc), 32'(exp_exc));
        if (exp_exc == EXC_NONE) begin
            check_val("mem_req_count", mem_cnt - m0, 1);
            check_val("o_mem_addr", last_addr, exp_pa);
            check_val("o_mem_uncached", 32'(last_unc), 32'(exp_unc));
            check_val("o_mem_we", 32'(last_we), 32'(we));
            if (we) begin
                check_val("o_mem_wdata", last_wdata, ~va);
                check_val("o_mem_wstrb", 32'(last_wstrb), 32'(4'hf >> lane));
            end else begin
                check_val("o_rsp_rdata", rdata, exp_pa ^ RD_KEY);
            end
        end else begin
            checks++;
            assert (mem_cnt == m0) else begin
                $display("Faulting request at %h reached memory", va);
                errors++;
            end
            check_val("o_rsp_rdata", rdata, 32'h0);
        end
    endtask

    function automatic tlb_half_t mk_half(input logic v, input logic d, input logic [1:0] plv,
                                          input logic [19:0] ppn);
        tlb_half_t h;
        h = '{valid: v, dirty: d, mat: 2'd1, plv: plv, ppn: ppn};
        return h;
    endfunction

    task automatic write_tlb(input int idx, input logic [18:0] vppn, input logic [9:0] asid,
                             input logic g, input tlb_half_t ev, input tlb_half_t od);
        @(posedge clk);
        #1;
        i_tlb_we      = 1'b1;
        i_tlb_w_index = idx[`MMU_TLB_IDX_W-1:0];
        i_tlb_w_entry = '{exist: 1'b1, vppn: vppn, asid: asid, g: g, even: ev, odd: od};
        @(posedge clk);
        #1;
        i_tlb_we = 1'b0;
    endtask

    task automatic invalidate(input logic [4:0] op, input logic [9:0] asid, input logic [31:0] va);
        @(posedge clk);
        #1;
        i_inv_valid = 1'b1;
        i_inv_op    = op;
        i_inv_asid  = asid;
        i_inv_va    = va;
        @(posedge clk);
        #1;
        i_inv_valid = 1'b0;
    endtask

    task automatic report(input string name, input int e0);
        $display("%-16s %s", name, (errors == e0) ? "pass" : "fail");
    endtask

    task automatic test_direct();
        int e0;
        e0 = errors;
        i_da = 1'b1;
        for (int l = 0; l < `MMU_N_LANES; l++) begin
            access(l, 32'h1000_0040 + 32'(l * 4), 1'b0, EXC_NONE,
                   32'h1000_0040 + 32'(l * 4), l != 0);  // Fetch lane is cached
        end
        for (int l = 1; l < `MMU_N_LANES; l++) begin
            access(l, 32'h1000_0080 + 32'(l * 4), 1'b1, EXC_NONE,
                   32'h1000_0080 + 32'(l * 4), 1'b1);
        end
        report("test_direct", e0);
    endtask

    task automatic test_window();
        int e0;
        e0 = errors;
        i_da = 1'b0;
        i_dmw0 = '0;
        i_dmw0.vseg = 3'h4;
        i_dmw0.pseg = 3'h1;
        i_dmw0.mat  = MAT_CC;
        i_dmw0.plv0 = 1'b1;
        i_dmw1 = '0;
        i_dmw1.vseg = 3'h5;
        i_dmw1.pseg = 3'h2;
        i_dmw1.plv3 = 1'b1;
        i_plv = 2'd0;
        access(1, 32'h8000_1234, 1'b0, EXC_NONE, 32'h2000_1234, 1'b0);
        access(2, 32'ha000_0010, 1'b0, EXC_TLBR, 32'h0, 1'b0);
        i_plv = 2'd3;
        access(2, 32'ha000_0010, 1'b0, EXC_NONE, 32'h4000_0010, 1'b1);
        i_plv = 2'd0;
        report("test_window", e0);
    endtask

    task automatic test_tlb();
        int e0;
        tlb_entry_t exp_ent;
        e0 = errors;
        write_tlb(2, 19'h00010, 10'd1, 1'b0, mk_half(1, 1, 0, 20'h00345),
                  mk_half(1, 1, 3, 20'h00678));
        write_tlb(5, 19'h00020, 10'd7, 1'b1, mk_half(1, 1, 3, 20'h00111),
                  mk_half(0, 0, 0, 20'h0));
        access(1, 32'h0002_0abc, 1'b0, EXC_NONE, 32'h0034_5abc, 1'b0);
        access(2, 32'h0002_1def, 1'b0, EXC_NONE, 32'h0067_8def, 1'b0);
        access(0, 32'h0004_0010, 1'b0, EXC_NONE, 32'h0011_1010, 1'b0);
        exp_ent = '{exist: 1'b1, vppn: 19'h00010, asid: 10'd1, g: 1'b0,
                    even: mk_half(1, 1, 0, 20'h00345), odd: mk_half(1, 1, 3, 20'h00678)};
        i_tlb_r_index = 4'd2;
        #1;
        checks++;
        assert (o_tlb_r_entry == exp_ent)
        else begin
            $display("Indexed read of entry 2 did not return the written entry");
            errors++;
        end
        report("test_tlb", e0);
    endtask

    task automatic test_faults();
        int e0;
        e0 = errors;
        write_tlb(3, 19'h00030, 10'd1, 1'b0, mk_half(0, 0, 0, 20'h00abc),
                  mk_half(1, 0, 0, 20'h00def));
        access(1, 32'h0010_0000, 1'b0, EXC_TLBR, 32'h0, 1'b0);
        access(0, 32'h0006_0100, 1'b0, EXC_PIF, 32'h0, 1'b0);
        access(1, 32'h0006_0100, 1'b0, EXC_PIL, 32'h0, 1'b0);
        access(2, 32'h0006_0100, 1'b1, EXC_PIS, 32'h0, 1'b0);
        i_plv = 2'd3;
        access(1, 32'h0006_1100, 1'b0, EXC_PPI, 32'h0, 1'b0);
        i_plv = 2'd0;
        access(2, 32'h0006_1100, 1'b1, EXC_PME, 32'h0, 1'b0);
        report("test_faults", e0);
    endtask

    task automatic test_inv();
        int e0;
        e0 = errors;
        invalidate(5'd5, 10'd1, 32'h0002_0000);
        access(1, 32'h0002_0abc, 1'b0, EXC_TLBR, 32'h0, 1'b0);
        invalidate(5'd5, 10'd7, 32'h0004_0000);   // Targets the global entry by ASID and page
        access(1, 32'h0004_0010, 1'b0, EXC_NONE, 32'h0011_1010, 1'b0);
        invalidate(5'd0, 10'd0, 32'h0);
        access(1, 32'h0004_0010, 1'b0, EXC_TLBR, 32'h0, 1'b0);
        report("test_inv", e0);
    endtask

    task automatic lane_stream(input int lane);
        int waits;
        exc_e exc;
        logic [31:0] va, rdata;
        for (int n = 0; n < 4; n++) begin
            va = $urandom & 32'hffff_fffc;
            do_req(lane, va, 1'b0, exc, rdata, waits);
            check_val("o_rsp_exc", 32'(exc), 32'(EXC_NONE));
            check_val("o_rsp_rdata", rdata, va ^ RD_KEY);
            checks++;
            assert (waits <= 2) else begin
                $display("Lane %0d waited for %0d other grants", lane, waits);
                errors++;
            end
        end
    endtask

    task automatic test_concurrent();
        int e0, r0;
        e0 = errors;
        r0 = mem_cnt;
        i_da = 1'b1;
        fork
            lane_stream(0);
            lane_stream(1);
            lane_stream(2);
        join
        check_val("mem_req_count", mem_cnt - r0, 12);
        report("test_concurrent", e0);
    endtask

    initial begin
        void'($urandom(32'hf81));
        errors = 0;
        checks = 0;
        cycles = 0;
        grant_cnt = 0;
        mem_cnt = 0;
        last_addr = '0;
        last_wdata = '0;
        last_wstrb = '0;
        last_unc = 1'b0;
        last_we = 1'b0;
        i_arst_n = 1'b0;
        i_da = 1'b1;
        i_datf = MAT_CC;
        i_datm = MAT_SUC;
        i_plv = 2'd0;
        i_asid = 10'd1;
        i_dmw0 = '0;
        i_dmw1 = '0;
        i_req_valid = '0;
        i_req_va = '0;
        i_req_we = '0;
        i_req_wstrb = '0;
        i_req_wdata = '0;
        i_tlb_we = 1'b0;
        i_tlb_w_index = '0;
        i_tlb_w_entry = '0;
        i_tlb_r_index = '0;
        i_inv_valid = 1'b0;
        i_inv_op = '0;
        i_inv_asid = '0;
        i_inv_va = '0;
        repeat (3) @(posedge clk);
        #1 i_arst_n = 1'b1;
        test_direct();
        test_window();
        test_tlb();
        test_faults();
        test_inv();
        test_concurrent();
        $display("Tests 6, checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* verilog.f */
+incdir+.
mmu_addr_pkg.sv
mmu_tlb_pkg.sv
mmu_tlb.sv
addr_trans.sv
mem_req_arbiter.sv
mmu_top.sv
tb_mmu_asserts.sv
tb_mmu.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module tb_mmu -o sim_mmu
./obj_dir/sim_mmu | tee sim.log

if grep -q "All checks passed" sim.log; then
    exit 0
else
    exit 1
fi
